//--- fb_scan_pkg.sv
package fb_scan_pkg;

  localparam int ADDR_W    = 16;  // Word address of the frame store.
  localparam int DATA_W    = 16;  // One RGB444 pixel per word.
  localparam int COLOR_W   = 4;
  localparam int H_W       = 10;
  localparam int V_W       = 10;
  localparam int BURST_LEN = 16;  // h_visible must be a multiple of this.

  // Width of the FIFO credit count between unpacker and reader.
  localparam int ROOM_W = 10;

  typedef struct packed {
    logic              enable;
    logic [ADDR_W-1:0] base;
    logic [H_W-1:0]    h_visible;
    logic [V_W-1:0]    v_visible;
  } fb_cfg_t;

  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] grn;
    logic [COLOR_W-1:0] blu;
    logic [H_W-1:0]     x;
    logic [V_W-1:0]     y;
    logic [ADDR_W-1:0]  addr;
    logic               last;  // Final pixel of the frame.
  } pix_t;

  typedef enum logic [1:0] {
    REG_CTRL = 2'd0,
    REG_BASE = 2'd1,
    REG_HVIS = 2'd2,
    REG_VVIS = 2'd3
  } reg_addr_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_DRAIN
  } rd_state_e;

endpackage

//--- fb_scan_regs.sv
`timescale 1ns/10ps

module fb_scan_regs
  import fb_scan_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      reg_wr,
  input  reg_addr_e reg_addr,
  input  logic [15:0] reg_wdata,
  output fb_cfg_t   cfg
);

  fb_cfg_t cfg_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (reg_wr) begin
      case (reg_addr)
        REG_CTRL: cfg_q.enable    <= reg_wdata[0];
        REG_BASE: cfg_q.base      <= reg_wdata[ADDR_W-1:0];
        REG_HVIS: cfg_q.h_visible <= reg_wdata[H_W-1:0];
        REG_VVIS: cfg_q.v_visible <= reg_wdata[V_W-1:0];
        default: ;
      endcase
    end
  end

  assign cfg = cfg_q;

  // Only decoded addresses may be written.
  a_reg_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    reg_wr |-> !$isunknown(reg_addr) &&
               (reg_addr inside {REG_CTRL, REG_BASE, REG_HVIS, REG_VVIS})
  );

endmodule

//--- fb_frame_ram.sv
`timescale 1ns/10ps

// LATENCY is 2 or more.
module fb_frame_ram
  import fb_scan_pkg::*;
#(
  parameter int LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ram_wr,
  input  logic [ADDR_W-1:0] ram_waddr,
  input  logic [DATA_W-1:0] ram_wdata,
  input  logic              arvalid,
  input  logic [ADDR_W-1:0] araddr,
  input  logic [7:0]        arlen,
  output logic              arready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  output logic              rlast,
  input  logic              rready
);

  localparam int DLY_W = $clog2(LATENCY + 1);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  logic              busy_q;
  logic [DLY_W-1:0]  delay_q;
  logic [7:0]        left_q;  // Beats after the current one.
  logic              rvalid_q;
  logic              rlast_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_nx;
  logic [DATA_W-1:0] rdata_q;

  logic accept;
  logic start_beat;
  logic step;
  logic finish;

  assign arready    = !busy_q;  // One burst at a time.
  assign accept     = arvalid && arready;
  assign start_beat = busy_q && !rvalid_q && (delay_q == DLY_W'(1));
  assign step       = rvalid_q && rready && !rlast_q;
  assign finish     = rvalid_q && rready && rlast_q;
  assign addr_nx    = addr_q + 1'b1;

  always_ff @(posedge clk) begin
    if (ram_wr) begin
      mem[ram_waddr] <= ram_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      delay_q  <= '0;
      left_q   <= '0;
      rvalid_q <= 1'b0;
      rlast_q  <= 1'b0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        delay_q <= DLY_W'(LATENCY - 1);
        left_q  <= arlen;
      end
      if (start_beat) begin
        rvalid_q <= 1'b1;
        rlast_q  <= (left_q == 8'd0);
      end else if (busy_q && !rvalid_q) begin
        delay_q <= delay_q - 1'b1;
      end
      if (step) begin
        left_q  <= left_q - 1'b1;
        rlast_q <= (left_q == 8'd1);
      end
      if (finish) begin
        rvalid_q <= 1'b0;
        rlast_q  <= 1'b0;
        busy_q   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= araddr;
    end
    if (start_beat) begin
      rdata_q <= mem[addr_q];
    end else if (step) begin
      rdata_q <= mem[addr_nx];  // Next beat of the INCR burst.
      addr_q  <= addr_nx;
    end
  end

  assign rvalid = rvalid_q;
  assign rdata  = rdata_q;
  assign rlast  = rlast_q;

  a_r_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast)
  );

endmodule

//--- fb_burst_reader.sv
`timescale 1ns/10ps

module fb_burst_reader
  import fb_scan_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  fb_cfg_t           cfg,
  input  logic [ROOM_W-1:0] fifo_room,
  output logic              arvalid,
  output logic [ADDR_W-1:0] araddr,
  output logic [7:0]        arlen,
  input  logic              arready,
  input  logic              rvalid,
  input  logic              rready,
  input  logic              rlast,
  output logic              burst_issued,
  output logic              frame_start
);

  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int FW_W  = H_W + V_W;

  rd_state_e         state_q;
  logic [FW_W-1:0]   frame_words;
  logic [FW_W-1:0]   req_q;   // Words requested so far.
  logic [FW_W-1:0]   req_nx;
  logic [OUT_W-1:0]  out_q;   // Bursts in flight.
  logic [ADDR_W-1:0] araddr_q;
  logic              frame_start_q;
  logic              room_ok;
  logic              burst_done;
  logic              start_frame;

  assign frame_words = cfg.h_visible * cfg.v_visible;
  assign req_nx      = req_q + FW_W'(BURST_LEN);
  assign room_ok     = fifo_room >= ROOM_W'(BURST_LEN);
  assign burst_done  = rvalid && rready && rlast;

  // Room and credit only shrink on an issue, so arvalid holds until arready.
  assign arvalid      = (state_q == RD_ISSUE) && room_ok &&
                        (out_q < OUT_W'(MAX_OUTSTANDING));
  assign burst_issued = arvalid && arready;
  assign arlen        = 8'(BURST_LEN - 1);
  assign araddr       = araddr_q;
  assign frame_start  = frame_start_q;

  always_comb begin
    start_frame = 1'b0;
    case (state_q)
      RD_IDLE:  start_frame = cfg.enable;
      RD_DRAIN: start_frame = (out_q == '0) && cfg.enable;
      default:  start_frame = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q       <= RD_IDLE;
      req_q         <= '0;
      out_q         <= '0;
      frame_start_q <= 1'b0;
    end else begin
      frame_start_q <= start_frame;
      out_q <= out_q + OUT_W'(burst_issued) - OUT_W'(burst_done);
      case (state_q)
        RD_IDLE: begin
          if (start_frame) begin
            state_q <= RD_ISSUE;
            req_q   <= '0;
          end
        end
        RD_ISSUE: begin
          if (burst_issued) begin
            req_q <= req_nx;
            if (req_nx >= frame_words) begin
              state_q <= RD_DRAIN;
            end
          end
        end
        RD_DRAIN: begin
          if (start_frame) begin
            state_q <= RD_ISSUE;  // Enable still set, next frame.
            req_q   <= '0;
          end else if (out_q == '0) begin
            state_q <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_frame) begin
      araddr_q <= cfg.base;
    end else if (burst_issued) begin
      araddr_q <= araddr_q + ADDR_W'(BURST_LEN);
    end
  end

  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

endmodule

//--- fb_pixel_unpack.sv
`timescale 1ns/10ps

// FIFO_DEPTH is a power of two, at least 2 * BURST_LEN.
module fb_pixel_unpack
  import fb_scan_pkg::*;
#(
  parameter int FIFO_DEPTH = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  fb_cfg_t           cfg,
  input  logic              frame_start,
  input  logic              burst_issued,
  input  logic              rvalid,
  input  logic [DATA_W-1:0] rdata,
  output logic              rready,
  output logic [ROOM_W-1:0] fifo_room,
  output logic              pix_valid,
  output pix_t              pix,
  input  logic              pix_ready
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  pix_t              mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [ROOM_W-1:0] cnt_q;  // Entries in mem, output register excluded.
  logic [ROOM_W-1:0] rsv_q;  // Promised to issued bursts.
  logic [H_W-1:0]    x_q;
  logic [V_W-1:0]    y_q;
  logic [ADDR_W-1:0] addr_q;
  pix_t              beat;
  pix_t              pix_q;
  logic              pix_valid_q;

  logic push;
  logic load_out;
  logic pop_mem;
  logic bypass;
  logic line_end;
  logic frame_end;

  assign rready    = (rsv_q != '0);
  assign push      = rvalid && rready;
  assign load_out  = !pix_valid_q || pix_ready;
  assign pop_mem   = load_out && (cnt_q != '0);
  assign bypass    = load_out && (cnt_q == '0) && push;  // Straight to output.
  assign fifo_room = ROOM_W'(FIFO_DEPTH) - cnt_q - rsv_q;

  assign line_end  = (x_q == cfg.h_visible - 1'b1);
  assign frame_end = line_end && (y_q == cfg.v_visible - 1'b1);

  always_comb begin
    beat.red  = rdata[3*COLOR_W-1 -: COLOR_W];
    beat.grn  = rdata[2*COLOR_W-1 -: COLOR_W];
    beat.blu  = rdata[COLOR_W-1:0];
    beat.x    = x_q;
    beat.y    = y_q;
    beat.addr = addr_q;
    beat.last = frame_end;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      cnt_q       <= '0;
      rsv_q       <= '0;
      x_q         <= '0;
      y_q         <= '0;
      pix_valid_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + ROOM_W'(push && !bypass) - ROOM_W'(pop_mem);
      rsv_q <= rsv_q + (burst_issued ? ROOM_W'(BURST_LEN) : '0) - ROOM_W'(push);
      if (push && !bypass) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_mem) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (load_out) begin
        pix_valid_q <= pop_mem || bypass;
      end
      if (frame_start) begin
        x_q <= '0;
        y_q <= '0;
      end else if (push) begin
        if (line_end) begin
          x_q <= '0;
          y_q <= frame_end ? '0 : y_q + 1'b1;
        end else begin
          x_q <= x_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && !bypass) begin
      mem[wr_ptr_q] <= beat;
    end
    if (pop_mem) begin
      pix_q <= mem[rd_ptr_q];
    end else if (bypass) begin
      pix_q <= beat;
    end
    if (frame_start) begin
      addr_q <= cfg.base;
    end else if (push) begin
      addr_q <= addr_q + 1'b1;  // Raster order is contiguous.
    end
  end

  assign pix_valid = pix_valid_q;
  assign pix       = pix_q;

  // Credit from the reader must keep the FIFO from overflowing.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> (cnt_q != ROOM_W'(FIFO_DEPTH))
  );

endmodule

//--- fb_scan_top.sv
`timescale 1ns/10ps

module fb_scan_top
  import fb_scan_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 4,
  parameter int FIFO_DEPTH      = 64,
  parameter int LATENCY         = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reg_wr,
  input  reg_addr_e         reg_addr,
  input  logic [15:0]       reg_wdata,
  input  logic              ram_wr,
  input  logic [ADDR_W-1:0] ram_waddr,
  input  logic [DATA_W-1:0] ram_wdata,
  output logic              pix_valid,
  output pix_t              pix,
  input  logic              pix_ready
);

  fb_cfg_t           cfg;
  logic [ROOM_W-1:0] fifo_room;
  logic              burst_issued;
  logic              frame_start;

  logic              arvalid;
  logic [ADDR_W-1:0] araddr;
  logic [7:0]        arlen;
  logic              arready;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              rlast;
  logic              rready;

  fb_scan_regs regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .cfg       (cfg)
  );

  fb_burst_reader #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) reader_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .fifo_room    (fifo_room),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arready      (arready),
    .rvalid       (rvalid),
    .rready       (rready),
    .rlast        (rlast),
    .burst_issued (burst_issued),
    .frame_start  (frame_start)
  );

  fb_frame_ram #(
    .LATENCY (LATENCY)
  ) ram_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ram_wr    (ram_wr),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arlen     (arlen),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rlast     (rlast),
    .rready    (rready)
  );

  fb_pixel_unpack #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) unpack_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .frame_start  (frame_start),
    .burst_issued (burst_issued),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rready       (rready),
    .fifo_room    (fifo_room),
    .pix_valid    (pix_valid),
    .pix          (pix),
    .pix_ready    (pix_ready)
  );

endmodule

//--- tb_fb_scan.sv
`timescale 1ns/10ps

module tb_fb_scan
  import fb_scan_pkg::*;
();

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [H_W-1:0]    h;
    logic [V_W-1:0]    v;
    logic [7:0]        stall_pct;  // Percent chance of ready low.
    logic [15:0]       stall_at;   // Pixel index where a long stall begins.
    logic [15:0]       stall_len;
    logic [1:0]        frames;     // Frames collected with enable held.
  } case_t;

  localparam int NUM_CASES = 4;

  logic              clk;
  logic              rst_n;
  logic              reg_wr;
  reg_addr_e         reg_addr;
  logic [15:0]       reg_wdata;
  logic              ram_wr;
  logic [ADDR_W-1:0] ram_waddr;
  logic [DATA_W-1:0] ram_wdata;
  logic              pix_valid;
  pix_t              pix;
  logic              pix_ready;

  case_t             cases [NUM_CASES];
  logic [DATA_W-1:0] img [2**ADDR_W];  // Copy of what the frame store holds.
  integer            seed;
  int                errors;
  int                failed;
  bit                timed_out;

  fb_scan_top #(
    .MAX_OUTSTANDING (4),
    .FIFO_DEPTH      (64),
    .LATENCY         (2)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .ram_wr    (ram_wr),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic write_reg(input reg_addr_e a, input logic [15:0] d);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic fill_frame(input logic [ADDR_W-1:0] base, input int n);
    logic [DATA_W-1:0] w;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      w         = DATA_W'($random(seed));
      a         = base + ADDR_W'(i);
      img[a]    = w;
      ram_wr    = 1'b1;
      ram_waddr = a;
      ram_wdata = w;
    end
    @(negedge clk);
    ram_wr = 1'b0;
  endtask

  // Pixel k of a frame in raster order from the stored word.
  function automatic pix_t expected_pixel(input logic [ADDR_W-1:0] base, input int h,
                                          input int n, input int k);
    pix_t              p;
    logic [ADDR_W-1:0] a;
    a      = base + ADDR_W'(k);
    p.red  = img[a][11:8];
    p.grn  = img[a][7:4];
    p.blu  = img[a][3:0];
    p.x    = H_W'(k % h);
    p.y    = V_W'(k / h);
    p.addr = a;
    p.last = (k == n - 1);
    return p;
  endfunction

  task automatic check_idle(input int cycles, output int errs);
    errs = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      pix_ready = 1'b1;
      if (pix_valid) begin
        $display("mismatch at %0t: pix_valid is high with no frame enabled", $time);
        errs++;
      end
    end
  endtask

  task automatic collect(input int t, input case_t c, output int got, output int errs);
    int   n;
    int   total;
    int   k;
    int   cycles;
    int   limit;
    int   stall_left;
    bit   held;
    pix_t held_pix;
    pix_t exp;
    n          = int'(c.h) * int'(c.v);
    total      = n * int'(c.frames);
    k          = 0;
    cycles     = 0;
    held       = 1'b0;
    stall_left = -1;
    limit      = 2000 + 40 * total + int'(c.stall_len);
    errs       = 0;
    while (k < total && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (held && !pix_valid) begin
        $display("mismatch at %0t: test %0d pix_valid dropped before pixel %0d was taken",
                 $time, t, k);
        errs++;
      end else if (held && pix !== held_pix) begin
        $display("mismatch at %0t: test %0d pixel %0d changed while stalled", $time, t, k);
        errs++;
      end
      if (c.stall_len != 0 && k == int'(c.stall_at) && stall_left < 0) begin
        stall_left = int'(c.stall_len);
      end
      if (stall_left > 0) begin
        pix_ready = 1'b0;
        stall_left--;
      end else begin
        pix_ready = ({$random(seed)} % 100) >= c.stall_pct;
      end
      held     = pix_valid && !pix_ready;  // Transfer decided at the next rising edge.
      held_pix = pix;
      if (pix_valid && pix_ready) begin
        exp = expected_pixel(c.base, int'(c.h), n, k % n);
        if (pix !== exp) begin
          $display("mismatch at %0t: test %0d frame %0d pixel %0d got %h expected %h",
                   $time, t, k / n, k % n, pix, exp);
          errs++;
        end
        k++;
      end
    end
    got = k;
    if (k < total) begin
      $display("timeout in test %0d: %0d of %0d pixels arrived", t, k, total);
      timed_out = 1'b1;
      errs++;
    end
  endtask

  // Ready held high until the stream has been quiet for a while.
  task automatic drain(input int t, output int errs);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    errs   = 0;
    while (quiet < 64 && cycles < 20000) begin
      @(negedge clk);
      pix_ready = 1'b1;
      cycles++;
      quiet = pix_valid ? 0 : quiet + 1;
    end
    if (quiet < 64) begin
      $display("timeout in test %0d: pixels keep coming after enable was cleared", t);
      timed_out = 1'b1;
      errs++;
    end
  endtask

  initial begin
    int got;
    int errs;
    int derrs;
    seed      = 32'hc3a68f3a;
    errors    = 0;
    failed    = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = REG_CTRL;
    reg_wdata = '0;
    ram_wr    = 1'b0;
    ram_waddr = '0;
    ram_wdata = '0;
    pix_ready = 1'b0;

    // base, h, v, stall %, stall at, stall length, frames.
    cases[0] = '{16'h0000, 10'd16,  10'd2, 8'd0,  16'd0,   16'd0,   2'd1};
    cases[1] = '{16'h1000, 10'd64,  10'd3, 8'd50, 16'd0,   16'd0,   2'd1};
    cases[2] = '{16'h2400, 10'd128, 10'd4, 8'd0,  16'd200, 16'd200, 2'd1};
    cases[3] = '{16'h0800, 10'd32,  10'd2, 8'd0,  16'd0,   16'd0,   2'd2};

    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    check_idle(50, errs);
    $display("test 0: idle after reset, %0s", (errs == 0) ? "ok" : "failed");
    errors += errs;
    failed += (errs != 0);

    for (int t = 0; t < NUM_CASES && !timed_out; t++) begin
      fill_frame(cases[t].base, int'(cases[t].h) * int'(cases[t].v));
      write_reg(REG_BASE, 16'(cases[t].base));
      write_reg(REG_HVIS, 16'(cases[t].h));
      write_reg(REG_VVIS, 16'(cases[t].v));
      write_reg(REG_CTRL, 16'h0001);
      collect(t + 1, cases[t], got, errs);
      write_reg(REG_CTRL, 16'h0000);
      if (!timed_out) begin
        drain(t + 1, derrs);
        errs += derrs;
      end
      $display("test %0d: %0dx%0d at base %h, %0d frame(s), %0d pixels, %0s", t + 1,
               cases[t].h, cases[t].v, cases[t].base, cases[t].frames, got,
               (errs == 0) ? "ok" : "failed");
      errors += errs;
      failed += (errs != 0);
    end

    $display("%0d tests, %0d failed, %0d errors", NUM_CASES + 1, failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- compile.f
fb_scan_pkg.sv
fb_scan_regs.sv
fb_frame_ram.sv
fb_burst_reader.sv
fb_pixel_unpack.sv
fb_scan_top.sv
tb_fb_scan.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fb_scan
RTL_TOP    ?= fb_scan_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
